// ==== Makefile ====
# Verilator build and run of the SDRAM controller testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module controllerTb -f files.f -Mdir obj_dir -o VcontrollerTb

run: compile
	./obj_dir/VcontrollerTb | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/sdramPkg.sv ====
// SDRAM controller shared definitions
// field widths, SDRAM command codes and the two views of a command word,
// the per-cycle pin request and the decoded CPU access
`default_nettype none

package sdramPkg;

	localparam int RowWidth = 13;                  // row address bits, also the pin address width
	localparam int ColWidth = 10;                  // column address bits
	localparam int BankWidth = 2;                  // four banks
	localparam int DataWidth = 16;                 // x16 part

	localparam int CasLatency = 2;                 // read data CAS latency in clocks
	localparam logic [RowWidth-1:0] ModeWord = 13'h220; // burst length 1, CAS latency 2

	// command code, bit order is cke, cs, ras, cas, we
	typedef enum logic [4:0] {
		PowerUp     = 5'b00000,                    // cke and cs low during the power-up wait
		Nop         = 5'b10111,
		Activate    = 5'b10011,                    // row on the address
		Read        = 5'b10101,                    // a10 high selects auto-precharge
		Write       = 5'b10100,                    // a10 high selects auto-precharge
		Precharge   = 5'b10010,                    // a10 high for all banks
		AutoRefresh = 5'b10001,
		ModeSet     = 5'b10000                     // mode word on the address
	} sdramCmdCode;

	typedef struct packed {
		logic cke;                                 // clock enable, active high
		logic csL;
		logic rasL;
		logic casL;
		logic weL;
	} sdramCmdPins;

	// one command word, written as a code and read back as pins
	typedef union packed {
		sdramCmdCode code;
		sdramCmdPins pins;
	} sdramCmd;

	typedef struct packed {
		sdramCmd cmd;
		logic [RowWidth-1:0] addr;                 // row, column or mode word
		logic [BankWidth-1:0] bank;
	} sdramReq;

	typedef struct packed {
		logic [RowWidth-1:0] row;
		logic [ColWidth-1:0] col;
		logic [BankWidth-1:0] bank;
		logic write;                               // high for a CPU write cycle
	} cpuAccess;

endpackage

`default_nettype wire

// ==== controller/dramSequencer.sv ====
// SDRAM command sequencer
// runs the power-up initialisation, then serves periodic refresh and
// single-word CPU reads and writes with auto-precharge, one command per clock
`timescale 1ns/1ps
`default_nettype none

module dramSequencer import sdramPkg::*; #(
	parameter int PowerUpCycles = 5000,
	parameter int InitRefreshCount = 8
) (
	input  wire logic Clock,
	input  wire logic Reset_L,
	input  wire logic AccessReq,                   // cpu cycle to dram in progress
	input  wire logic DataStrobe,                  // write data is on the bus
	input  wire cpuAccess Access,
	input  wire logic RefreshDue,
	output sdramReq Req,                           // command for the pin stage
	output logic WriteEn,                          // drive write data next cycle
	output logic Capture,                          // load read data this edge
	output logic AckSet,                           // start of dtack
	output logic RefreshTaken,
	output logic InitDone                          // init sequence complete
);

	localparam int WaitWidth = $clog2(PowerUpCycles + CasLatency + 1);
	localparam int RoundWidth = $clog2(InitRefreshCount + 1);
	localparam int ApBit = 10;                     // auto-precharge / all-banks address bit
	localparam logic [RowWidth-1:0] ApMask = RowWidth'(1) << ApBit;

	typedef enum logic [4:0] {
		PowerUpWait, InitNop1, InitNop2, InitPrecharge, InitPrechargeNop,
		InitRefresh, InitRefreshNop1, InitRefreshNop2, InitRefreshNop3,
		InitModeSet, InitModeNop, Idle,
		RefNop, RefRefresh, RefNop1, RefNop2, RefNop3,
		ReadCmd, CasWait, WriteWait, WriteHold, AckWait
	} seqState;

	seqState state;
	seqState nextState;
	logic [WaitWidth-1:0] waitCount;               // power-up and cas wait
	logic [RoundWidth-1:0] roundCount;             // init refresh rounds done
	logic [RowWidth-1:0] colAddr;

	assign colAddr = RowWidth'(Access.col) | ApMask; // column with auto-precharge

	////////////////////////////////////////////////////////////////////
	// state, counters and init flag
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= PowerUpWait;
			waitCount <= WaitWidth'(PowerUpCycles - 1); // power-up wait starts at reset
			roundCount <= '0;
			InitDone <= 1'b0;
		end else begin
			state <= nextState;
			if (state == ReadCmd)
				waitCount <= WaitWidth'(CasLatency);
			else if (waitCount != '0)
				waitCount <= waitCount - 1'b1; // parks at zero
			if (state == InitRefreshNop3)
				roundCount <= roundCount + 1'b1;
			if (state == Idle)
				InitDone <= 1'b1;      // one cycle after the mode nop reaches the pins
		end
	end

	////////////////////////////////////////////////////////////////////
	// next state and command
	////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		Req.cmd.code = Nop;                        // nop unless a state says otherwise
		Req.addr = '0;
		Req.bank = '0;
		WriteEn = 1'b0;
		Capture = 1'b0;
		AckSet = 1'b0;
		RefreshTaken = 1'b0;
		case (state)
			PowerUpWait: begin
				Req.cmd.code = PowerUp;        // cke stays low
				if (waitCount == '0)
					nextState = InitNop1;
			end
			InitNop1: nextState = InitNop2;
			InitNop2: nextState = InitPrecharge;
			InitPrecharge: begin
				Req.cmd.code = Precharge;
				Req.addr = ApMask;             // all banks
				nextState = InitPrechargeNop;
			end
			InitPrechargeNop: nextState = InitRefresh;
			InitRefresh: begin
				Req.cmd.code = AutoRefresh;
				nextState = InitRefreshNop1;
			end
			InitRefreshNop1: nextState = InitRefreshNop2;
			InitRefreshNop2: nextState = InitRefreshNop3;
			InitRefreshNop3: begin
				if (roundCount == RoundWidth'(InitRefreshCount - 1))
					nextState = InitModeSet;
				else
					nextState = InitRefresh;
			end
			InitModeSet: begin
				Req.cmd.code = ModeSet;
				Req.addr = ModeWord;
				nextState = InitModeNop;
			end
			InitModeNop: nextState = Idle;
			Idle: begin
				if (RefreshDue) begin          // refresh wins over a waiting access
					Req.cmd.code = Precharge;
					Req.addr = ApMask;
					RefreshTaken = 1'b1;
					nextState = RefNop;
				end else if (AccessReq) begin
					Req.cmd.code = Activate;
					Req.addr = Access.row;
					Req.bank = Access.bank;
					nextState = Access.write ? WriteWait : ReadCmd;
				end
			end
			RefNop: nextState = RefRefresh;
			RefRefresh: begin
				Req.cmd.code = AutoRefresh;
				nextState = RefNop1;
			end
			RefNop1: nextState = RefNop2;
			RefNop2: nextState = RefNop3;
			RefNop3: nextState = Idle;
			ReadCmd: begin
				Req.cmd.code = Read;
				Req.addr = colAddr;
				Req.bank = Access.bank;
				nextState = CasWait;
			end
			CasWait: begin
				if (waitCount == '0) begin     // read data on the dq pins now
					Capture = 1'b1;
					AckSet = 1'b1;
					nextState = AckWait;
				end
			end
			WriteWait: begin
				if (DataStrobe) begin          // cpu data valid, no limit on the wait
					Req.cmd.code = Write;
					Req.addr = colAddr;
					Req.bank = Access.bank;
					WriteEn = 1'b1;
					AckSet = 1'b1;
					nextState = WriteHold;
				end
			end
			WriteHold: begin
				WriteEn = 1'b1;                // second cycle of driven dq
				nextState = AckWait;
			end
			AckWait: begin
				if (!AccessReq)
					nextState = Idle;          // cpu has ended the bus cycle
			end
			default: nextState = Idle;
		endcase
	end

endmodule

`default_nettype wire

// ==== controller/refreshScheduler.sv ====
// Refresh interval timer
// counts down from the end of initialisation and raises a refresh request
// that holds until the sequencer takes it
`timescale 1ns/1ps
`default_nettype none

module refreshScheduler #(
	parameter int RefreshInterval = 375
) (
	input  wire logic Clock,
	input  wire logic Reset_L,
	input  wire logic Enable,                      // high once init is done
	input  wire logic RefreshTaken,
	output logic RefreshDue
);

	localparam int CountWidth = $clog2(RefreshInterval + 1);

	logic [CountWidth-1:0] count;
	logic started;                                 // enable seen
	logic reload;

	assign reload = RefreshTaken | (Enable & ~started); // first rise of enable or refresh served

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count <= '0;
			started <= 1'b0;
			RefreshDue <= 1'b0;
		end else begin
			started <= started | Enable;
			if (reload)
				count <= CountWidth'(RefreshInterval - 1);
			else if (count != '0)
				count <= count - 1'b1;
			if (RefreshTaken)
				RefreshDue <= 1'b0;
			else if (started && count == '0)
				RefreshDue <= 1'b1;            // held until taken
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
common/sdramPkg.sv
controller/refreshScheduler.sv
controller/dramSequencer.sv
source/cpuBusPort.sv
source/sdramPins.sv
source/m68kSdramController.sv
verification/sdramModel.sv
verification/controllerTb.sv

// ==== source/cpuBusPort.sv ====
// CPU bus port
// decodes the 68000 strobes and dram select, splits the word address into
// row, column and bank, and holds dtack until the address strobe goes away
`timescale 1ns/1ps
`default_nettype none

module cpuBusPort import sdramPkg::*; (
	input  wire logic Clock,
	input  wire logic Reset_L,
	input  wire logic [31:0] Address,              // byte address from the cpu
	input  wire logic AS_L,
	input  wire logic DramSelect_L,
	input  wire logic UDS_L,
	input  wire logic LDS_L,
	input  wire logic WE_L,
	input  wire logic AckSet,                      // pulse from the sequencer
	output logic AccessReq,
	output logic DataStrobe,
	output cpuAccess Access,
	output logic Dtack_L
);

	assign AccessReq = ~AS_L & ~DramSelect_L;      // cpu cycle addressed to dram
	assign DataStrobe = ~UDS_L | ~LDS_L;           // either byte lane, no masking

	// word address split, bit 0 is the byte select
	assign Access.row = Address[23:11];
	assign Access.col = Address[10:1];
	assign Access.bank = Address[25:24];
	assign Access.write = ~WE_L;

	// dtack register
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			Dtack_L <= 1'b1;
		else if (AS_L)
			Dtack_L <= 1'b1;                       // end of the bus cycle
		else if (AckSet)
			Dtack_L <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== source/m68kSdramController.sv ====
// 68000 SDRAM controller top level
// 32M x16 SDRAM, CAS latency 2, single-word access with auto-precharge
// and periodic auto-refresh, CPU held in reset until init is done
`timescale 1ns/1ps
`default_nettype none

module m68kSdramController import sdramPkg::*; #(
	parameter int PowerUpCycles = 5000,            // power-up wait in clocks
	parameter int InitRefreshCount = 8,
	parameter int RefreshInterval = 375
) (
	input  wire logic Clock,
	input  wire logic Reset_L,
	input  wire logic [31:0] Address,
	input  wire logic [DataWidth-1:0] DataIn,
	input  wire logic AS_L,
	input  wire logic UDS_L,
	input  wire logic LDS_L,
	input  wire logic WE_L,
	input  wire logic DramSelect_L,
	input  wire logic [DataWidth-1:0] SDram_DqIn,
	output logic [DataWidth-1:0] DataOut,
	output logic Dtack_L,
	output logic ResetOut_L,
	output logic SDram_CKE,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output logic [RowWidth-1:0] SDram_Addr,
	output logic [BankWidth-1:0] SDram_BA,
	output logic [DataWidth-1:0] SDram_DqOut,
	output logic SDram_DqOe
);

	logic accessReq;
	logic dataStrobe;
	cpuAccess access;
	logic ackSet;
	logic refreshDue;
	logic refreshTaken;
	logic initDone;
	sdramReq req;                                  // sequencer to pin stage
	logic writeEn;
	logic capture;

	assign ResetOut_L = initDone;                  // cpu reset held while init pending

	cpuBusPort u_cpuBusPort (
		.Clock, .Reset_L, .Address, .AS_L, .DramSelect_L, .UDS_L, .LDS_L, .WE_L,
		.AckSet(ackSet), .AccessReq(accessReq), .DataStrobe(dataStrobe),
		.Access(access), .Dtack_L
	);

	refreshScheduler #(.RefreshInterval(RefreshInterval)) u_refreshScheduler (
		.Clock, .Reset_L, .Enable(initDone), .RefreshTaken(refreshTaken),
		.RefreshDue(refreshDue)
	);

	dramSequencer #(
		.PowerUpCycles(PowerUpCycles),
		.InitRefreshCount(InitRefreshCount)
	) u_dramSequencer (
		.Clock, .Reset_L, .AccessReq(accessReq), .DataStrobe(dataStrobe),
		.Access(access), .RefreshDue(refreshDue), .Req(req), .WriteEn(writeEn),
		.Capture(capture), .AckSet(ackSet), .RefreshTaken(refreshTaken),
		.InitDone(initDone)
	);

	sdramPins u_sdramPins (
		.Clock, .Reset_L, .Req(req), .WriteEn(writeEn), .DataIn, .Capture(capture),
		.SDram_DqIn, .SDram_CKE, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
		.SDram_Addr, .SDram_BA, .SDram_DqOut, .SDram_DqOe, .DataOut
	);

endmodule

`default_nettype wire

// ==== source/sdramPins.sv ====
// SDRAM pin stage
// registers each cycle's command, address, bank and write data onto the
// SDRAM pins and captures read data for the CPU
`timescale 1ns/1ps
`default_nettype none

module sdramPins import sdramPkg::*; (
	input  wire logic Clock,
	input  wire logic Reset_L,
	input  wire sdramReq Req,
	input  wire logic WriteEn,
	input  wire logic [DataWidth-1:0] DataIn,      // cpu write data
	input  wire logic Capture,
	input  wire logic [DataWidth-1:0] SDram_DqIn,
	output logic SDram_CKE,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output logic [RowWidth-1:0] SDram_Addr,
	output logic [BankWidth-1:0] SDram_BA,
	output logic [DataWidth-1:0] SDram_DqOut,
	output logic SDram_DqOe,                       // board drives dq while high
	output logic [DataWidth-1:0] DataOut           // read data back to the cpu
);

	// command pins and dq enable, power-up command while in reset
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{SDram_CKE, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= PowerUp;
			SDram_DqOe <= 1'b0;
		end else begin
			SDram_CKE <= Req.cmd.pins.cke;
			SDram_CS_L <= Req.cmd.pins.csL;
			SDram_RAS_L <= Req.cmd.pins.rasL;
			SDram_CAS_L <= Req.cmd.pins.casL;
			SDram_WE_L <= Req.cmd.pins.weL;
			SDram_DqOe <= WriteEn;
		end
	end

	// address and data path
	always_ff @(posedge Clock) begin
		SDram_Addr <= Req.addr;
		SDram_BA <= Req.bank;
		if (WriteEn)
			SDram_DqOut <= DataIn;
		if (Capture)
			DataOut <= SDram_DqIn;                 // held until the next read
	end

endmodule

`default_nettype wire

// ==== verification/controllerCases.txt ====
# op address data name, op P is write then read back, W write only, R read and expect data
# address is the cpu byte address in hex, data a hex word or rand for a seeded random word
P 00000000 1234 firstWord
P 00000002 a55a nextColumn
P 01000000 5aa5 bank1SameRowCol
P 02000000 0f0f bank2SameRowCol
P 03000000 f0f0 bank3SameRowCol
P 000007fe 7e7e lastColumn
P 00fff800 c3c3 lastRow
P 03fffffe 8001 topWord
W 00001000 beef rowOneWrite
W 01001000 cafe rowOneBank1Write
R 00001000 beef rowOneRead
R 01001000 cafe rowOneBank1Read
R 00000000 1234 firstWordKept
P 00123456 rand randomOne
P 02abcdee rand randomTwo

// ==== verification/controllerTb.sv ====
// Testbench for the 68000 SDRAM controller
// runs CPU bus cycles from the cases file against a behavioural SDRAM and
// watches the SDRAM command stream for init, refresh and address checks
`timescale 1ns/1ps
`default_nettype none

module controllerTb;

	localparam int PowerUpCycles = 20;
	localparam int InitRefreshCount = 8;
	localparam int RefreshInterval = 60;
	localparam int ReadDtackDelay = 3;             // cas latency plus one
	localparam logic [12:0] ModeWordExp = 13'h220; // burst 1, cas latency 2
	localparam logic [3:0] CmdActivate = 4'b0011;  // cs, ras, cas, we
	localparam logic [3:0] CmdRead = 4'b0101;
	localparam logic [3:0] CmdWrite = 4'b0100;
	localparam logic [3:0] CmdPrecharge = 4'b0010;
	localparam logic [3:0] CmdRefresh = 4'b0001;
	localparam logic [3:0] CmdModeSet = 4'b0000;

	logic Clock;
	logic Reset_L;
	logic [31:0] Address;
	logic [15:0] DataIn;
	logic AS_L, UDS_L, LDS_L, WE_L, DramSelect_L;
	logic [15:0] SDram_DqIn;
	logic [15:0] DataOut;
	logic Dtack_L, ResetOut_L;
	logic SDram_CKE, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L;
	logic [12:0] SDram_Addr;
	logic [1:0] SDram_BA;
	logic [15:0] SDram_DqOut;
	logic SDram_DqOe;

	int errors, checks, cycle, cyclesCkeLow, initRefreshes, idleRefreshes;
	int lastRefreshCycle, modeCycle, readCycle, oeLeft;
	bit running, modeSeen, busActive, idleWindow, prechargeSeen, prevDtack;
	logic [31:0] curAddr;                          // access the monitor expects
	logic curWrite;
	logic [15:0] curData;
	string curName;

	m68kSdramController #(
		.PowerUpCycles(PowerUpCycles),
		.InitRefreshCount(InitRefreshCount),
		.RefreshInterval(RefreshInterval)
	) u_m68kSdramController (
		.Clock, .Reset_L, .Address, .DataIn, .AS_L, .UDS_L, .LDS_L, .WE_L, .DramSelect_L,
		.SDram_DqIn, .DataOut, .Dtack_L, .ResetOut_L, .SDram_CKE, .SDram_CS_L,
		.SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L, .SDram_Addr, .SDram_BA,
		.SDram_DqOut, .SDram_DqOe
	);

	sdramModel u_sdramModel (
		.Clock, .Cke(SDram_CKE), .CsL(SDram_CS_L), .RasL(SDram_RAS_L),
		.CasL(SDram_CAS_L), .WeL(SDram_WE_L), .Addr(SDram_Addr), .Ba(SDram_BA),
		.DqWrite(SDram_DqOut), .DqOe(SDram_DqOe), .DqRead(SDram_DqIn)
	);

	always #50 Clock = ~Clock;                     // 100 ns period

	//////////////////////////////////////////////////////////////////////
	// command monitor sampling the pins at the falling edge
	//////////////////////////////////////////////////////////////////////
	always @(negedge Clock) begin
		logic [3:0] cmd;
		logic [12:0] expCol;
		logic expRst;
		if (running) begin
			cycle++;
			cmd = {SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};
			expCol = 13'h400 | {3'b000, curAddr[10:1]}; // column with auto-precharge
			expRst = modeSeen && (cycle - modeCycle >= 2);
			if (!SDram_CKE) begin
				cyclesCkeLow++;
				if (modeSeen) begin
					$display("clock enable went low after initialisation at cycle %0d", cycle);
					errors++;
				end
			end
			if (ResetOut_L !== expRst) begin
				$display("mismatch init cpu reset expected %b actual %b", expRst, ResetOut_L);
				errors++;
			end
			if (!Dtack_L && !busActive) begin
				$display("dtack low outside a cpu cycle at cycle %0d", cycle);
				errors++;
			end
			if (SDram_CKE) begin
				case (cmd)
					CmdActivate: begin
						checks++;
						if ({SDram_BA, SDram_Addr} !== {curAddr[25:24], curAddr[23:11]}) begin
							$display("mismatch %s activate expected %h actual %h", curName,
								{curAddr[25:24], curAddr[23:11]}, {SDram_BA, SDram_Addr});
							errors++;
						end
						if (!busActive) begin
							$display("activate without a cpu cycle at cycle %0d", cycle);
							errors++;
						end
					end
					CmdRead: begin
						checks++;
						readCycle = cycle;
						if (curWrite) begin
							$display("read command during the write cycle of %s", curName);
							errors++;
						end
						if ({SDram_BA, SDram_Addr} !== {curAddr[25:24], expCol}) begin
							$display("mismatch %s read expected %h actual %h", curName,
								{curAddr[25:24], expCol}, {SDram_BA, SDram_Addr});
							errors++;
						end
					end
					CmdWrite: begin
						checks++;
						oeLeft = 2;                // dq driven for two cycles
						if (!curWrite) begin
							$display("write command during the read cycle of %s", curName);
							errors++;
						end
						if ({SDram_BA, SDram_Addr} !== {curAddr[25:24], expCol}) begin
							$display("mismatch %s write expected %h actual %h", curName,
								{curAddr[25:24], expCol}, {SDram_BA, SDram_Addr});
							errors++;
						end
						if (SDram_DqOut !== curData) begin
							$display("mismatch %s write data expected %h actual %h", curName,
								curData, SDram_DqOut);
							errors++;
						end
						if (!SDram_DqOe) begin
							$display("dq not driven with the write of %s", curName);
							errors++;
						end
						if (Dtack_L) begin
							$display("dtack not low with the write of %s", curName);
							errors++;
						end
					end
					CmdPrecharge: begin
						prechargeSeen = 1'b1;
						if (!SDram_Addr[10]) begin
							$display("precharge without a10 high at cycle %0d", cycle);
							errors++;
						end
					end
					CmdRefresh: begin
						checks++;
						if (!prechargeSeen) begin
							$display("auto-refresh with no precharge before it at cycle %0d", cycle);
							errors++;
						end
						if (modeSeen)
							prechargeSeen = 1'b0;
						else
							initRefreshes++;
						if (idleWindow) begin
							if (idleRefreshes > 0 &&
								cycle - lastRefreshCycle > RefreshInterval + 10) begin
								$display("mismatch idle refresh gap expected at most %0d actual %0d",
									RefreshInterval + 10, cycle - lastRefreshCycle);
								errors++;
							end
							idleRefreshes++;
						end
						lastRefreshCycle = cycle;
					end
					CmdModeSet: begin
						checks += 3;
						if (SDram_Addr !== ModeWordExp) begin
							$display("mismatch init mode word expected %h actual %h",
								ModeWordExp, SDram_Addr);
							errors++;
						end
						if (initRefreshes != InitRefreshCount) begin
							$display("mismatch init refreshes expected %0d actual %0d",
								InitRefreshCount, initRefreshes);
							errors++;
						end
						if (cyclesCkeLow != PowerUpCycles) begin
							$display("mismatch init power-up cycles expected %0d actual %0d",
								PowerUpCycles, cyclesCkeLow);
							errors++;
						end
						modeSeen = 1'b1;
						modeCycle = cycle;
					end
					default: ;                     // nop
				endcase
			end
			// read data must be ready when dtack falls
			if (prevDtack && !Dtack_L && !curWrite) begin
				checks++;
				if (cycle - readCycle != ReadDtackDelay) begin
					$display("mismatch %s read dtack delay expected %0d actual %0d", curName,
						ReadDtackDelay, cycle - readCycle);
					errors++;
				end
			end
			prevDtack = Dtack_L;
			if (SDram_DqOe) begin
				if (oeLeft == 0) begin
					$display("dq driven outside a write at cycle %0d", cycle);
					errors++;
				end else
					oeLeft--;
			end else if (oeLeft != 0) begin
				$display("dq drive ended early at cycle %0d", cycle);
				errors++;
				oeLeft = 0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// one 68000 bus cycle to the dram
	//////////////////////////////////////////////////////////////////////
	task automatic cpuCycle(input bit isWrite, input logic [31:0] addr,
		input logic [15:0] data, input string name);
		int waited;
		@(posedge Clock);
		#1;
		curAddr = addr;
		curWrite = isWrite;
		curData = data;
		curName = name;
		busActive = 1'b1;
		Address = addr;
		DataIn = data;
		WE_L = ~isWrite;
		DramSelect_L = 1'b0;
		AS_L = 1'b0;
		if (isWrite) begin
			repeat (2) @(posedge Clock);           // write strobes come later
			#1;
		end
		UDS_L = 1'b0;
		LDS_L = 1'b0;
		waited = 0;
		@(negedge Clock);
		while (Dtack_L && waited < 40) begin
			@(negedge Clock);
			waited++;
		end
		checks++;
		if (Dtack_L) begin
			$display("timeout waiting for dtack in %s", name);
			errors++;
		end else if (!isWrite && DataOut !== data) begin
			$display("mismatch %s read data expected %h actual %h", name, data, DataOut);
			errors++;
		end
		@(posedge Clock);
		#1;
		AS_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		DramSelect_L = 1'b1;
		WE_L = 1'b1;
		waited = 0;
		@(negedge Clock);
		while (!Dtack_L && waited < 2) begin
			@(negedge Clock);
			waited++;
		end
		checks++;
		if (!Dtack_L) begin
			$display("dtack still low two cycles after the address strobe rose in %s", name);
			errors++;
		end
		busActive = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		string line;
		string op;
		string dataStr;
		string name;
		logic [31:0] addr;
		logic [15:0] data;
		int fd;
		int fields;
		int waited;
		Clock = 1'b0;
		Reset_L = 1'b0;
		Address = '0;
		DataIn = '0;
		AS_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		WE_L = 1'b1;
		DramSelect_L = 1'b1;
		curAddr = '0;
		curWrite = 1'b0;
		curData = '0;
		curName = "init";
		prevDtack = 1'b1;
		void'($urandom(14));
		repeat (2) @(posedge Clock);
		#1;
		Reset_L = 1'b1;
		@(posedge Clock);
		running = 1'b1;
		waited = 0;
		while (!ResetOut_L && waited < 200) begin
			@(negedge Clock);
			waited++;
		end
		if (!ResetOut_L) begin
			$display("timeout waiting for the end of initialisation");
			errors++;
		end
		fd = $fopen("verification/controllerCases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the cases file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				fields = $sscanf(line, "%s %h %s %s", op, addr, dataStr, name);
				if (fields == 4 && line.getc(0) != "#") begin
					if (dataStr == "rand")
						data = 16'($urandom);      // seeded word
					else
						void'($sscanf(dataStr, "%h", data));
					if (op == "W" || op == "P")
						cpuCycle(1'b1, addr, data, name);
					if (op == "R" || op == "P")
						cpuCycle(1'b0, addr, data, name);
				end
			end
			$fclose(fd);
		end
		idleWindow = 1'b1;                         // refresh only with no cpu cycles
		repeat (300) @(negedge Clock);
		idleWindow = 1'b0;
		checks++;
		if (idleRefreshes < 300 / (RefreshInterval + 10)) begin
			$display("mismatch idle refresh count expected at least %0d actual %0d",
				300 / (RefreshInterval + 10), idleRefreshes);
			errors++;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// overall limit on simulated time
	initial begin
		#500000;
		$display("simulation time limit reached");
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/sdramModel.sv ====
// Behavioural SDRAM for the controller testbench
// decodes commands on the rising clock, keeps one open row per bank,
// stores written words sparsely and returns read data after CAS latency 2
`timescale 1ns/1ps
`default_nettype none

module sdramModel (
	input  wire logic Clock,
	input  wire logic Cke,
	input  wire logic CsL,
	input  wire logic RasL,
	input  wire logic CasL,
	input  wire logic WeL,
	input  wire logic [12:0] Addr,
	input  wire logic [1:0] Ba,
	input  wire logic [15:0] DqWrite,              // controller side of dq
	input  wire logic DqOe,
	output logic [15:0] DqRead
);

	logic [15:0] mem [logic [24:0]];               // {bank, row, col}
	logic [12:0] openRow [4];
	logic [15:0] readStage;                        // first latency stage
	logic readPending;
	logic [24:0] key;

	assign key = {Ba, openRow[Ba], Addr[9:0]};     // column in the low ten bits

	initial begin
		DqRead = '0;
		readPending = 1'b0;
	end

	always @(posedge Clock) begin
		readPending <= 1'b0;
		if (readPending)
			DqRead <= readStage;                   // valid at the controller's next edge
		if (Cke && !CsL) begin
			case ({RasL, CasL, WeL})
				3'b011: openRow[Ba] <= Addr;       // activate
				3'b101: begin                      // read
					readStage <= mem.exists(key) ? mem[key] : 16'hdead;
					readPending <= 1'b1;
				end
				3'b100: if (DqOe) mem[key] = DqWrite; // write, dq must be driven
				default: ;                         // nop, refresh, precharge, mode
			endcase
		end
	end

endmodule

`default_nettype wire
